// ==== logic/sched_pkg.sv ====
package sched_pkg;

   localparam int sample_w     = 24;
   localparam int word_w       = 32;
   localparam int aq_addr_w    = 9;    // 512 capture entries
   localparam int sdram_addr_w = 21;

   localparam int fill_words   = 64;   // words stored before playback starts

   localparam int tx_depth     = 32;
   localparam int tx_ptr_w     = 5;    // log2 of tx_depth
   localparam int tx_fill_w    = 6;    // holds 0 to tx_depth
   localparam int tx_high_mark = 16;   // reads stop above this reserved fill
   localparam int tx_low_mark  = 5;    // reads resume below this reserved fill

   typedef enum logic [2:0]
   {
      st_wait,
      st_store,
      st_play,
      st_hold,
      st_finished
   } sched_state_e;

   typedef enum logic [1:0]
   {
      op_none,
      op_write,
      op_read
   } issue_op_e;

   // one SDRAM command as it leaves the issuer
   typedef struct packed
   {
      logic                    wr;
      logic [sdram_addr_w-1:0] address;
      logic [word_w-1:0]       data;
   } sdram_cmd_t;

endpackage

// ==== logic/aq_capture.sv ====
`timescale 1ns/1ps

module aq_capture
   import sched_pkg::*;
(
   input  logic                rst,
   input  logic                write_clk,
   input  logic                sample_strobe,
   input  logic [sample_w-1:0] sample_data,
   input  logic                bb_clk,
   input  logic                aq_pop,
   output logic                aq_pending,
   output logic [sample_w-1:0] aq_word
);

   logic [sample_w-1:0]  mem [0:(1 << aq_addr_w)-1];

   logic [aq_addr_w-1:0] wr_ptr;
   logic [aq_addr_w-1:0] wr_ptr_next;
   logic [aq_addr_w-1:0] wr_gray;

   logic [aq_addr_w-1:0] gray_meta;
   logic [aq_addr_w-1:0] gray_sync;
   logic [aq_addr_w-1:0] wr_ptr_sync;
   logic [aq_addr_w-1:0] rd_ptr;

   assign wr_ptr_next = wr_ptr + 1'b1;

   always_ff @(posedge write_clk)
   begin
      if (sample_strobe)
         mem[wr_ptr] <= sample_data;
   end

   // the gray copy moves with the binary pointer so only one bit flips per sample
   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         wr_ptr  <= '0;
         wr_gray <= '0;
      end
      else if (sample_strobe)
      begin
         wr_ptr  <= wr_ptr_next;
         wr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
      end
   end

   always_ff @(posedge bb_clk or posedge rst)
   begin
      if (rst)
      begin
         gray_meta <= '0;
         gray_sync <= '0;
      end
      else
      begin
         gray_meta <= wr_gray;
         gray_sync <= gray_meta;
      end
   end

   always_comb
   begin
      wr_ptr_sync[aq_addr_w-1] = gray_sync[aq_addr_w-1];
      for (int i = aq_addr_w - 2; i >= 0; i--)
         wr_ptr_sync[i] = wr_ptr_sync[i+1] ^ gray_sync[i];
   end

   always_ff @(posedge bb_clk or posedge rst)
   begin
      if (rst)
         rd_ptr <= '0;
      else if (aq_pop)
         rd_ptr <= rd_ptr + 1'b1;
   end

   assign aq_pending = (wr_ptr_sync != rd_ptr);
   assign aq_word    = mem[rd_ptr];   // entry is stable once its pointer has crossed

   a_pop_needs_pending : assert property (
      @(posedge bb_clk) disable iff (rst) aq_pop |-> aq_pending
   );

endmodule

// ==== logic/fill_scheduler.sv ====
`timescale 1ns/1ps

module fill_scheduler
   import sched_pkg::*;
(
   input  logic                 bb_clk,
   input  logic                 rst,
   input  logic                 aq_pending,
   input  logic                 store_full,
   input  logic                 play_done,
   input  logic [tx_fill_w-1:0] tx_fill,
   output issue_op_e            op,
   output sched_state_e         state,
   output logic                 bb_filled,
   output logic                 tx_ready_for_first_read,
   output logic                 finished
);

   always_ff @(posedge bb_clk or posedge rst)
   begin
      if (rst)
      begin
         state                   <= st_wait;
         bb_filled               <= 1'b0;
         tx_ready_for_first_read <= 1'b0;
      end
      else
      begin
         case (state)
            st_wait:
            begin
               if (store_full)
                  state <= st_play;
               else if (aq_pending)
                  state <= st_store;
            end
            st_store:
            begin
               // stays while samples remain so back to back writes need no detour
               if (store_full || !aq_pending)
                  state <= st_wait;
            end
            st_play:
            begin
               bb_filled <= 1'b1;
               if (tx_fill > tx_high_mark)
               begin
                  state                   <= st_hold;
                  tx_ready_for_first_read <= 1'b1;
               end
               else if (play_done)
                  state <= st_finished;
            end
            st_hold:
            begin
               if (play_done)
                  state <= st_finished;
               else if (tx_fill < tx_low_mark)
                  state <= st_play;
            end
            st_finished:
               state <= st_finished;
            default:
               state <= st_wait;
         endcase
      end
   end

   // the level checks keep a stale op from slipping out while the state catches up
   always_comb
   begin
      op = op_none;
      case (state)
         st_store:
            if (aq_pending && !store_full)
               op = op_write;
         st_play:
            if (!play_done && (tx_fill <= tx_high_mark))
               op = op_read;
         default:
            op = op_none;
      endcase
   end

   assign finished = (state == st_finished);

   a_quiet_when_finished : assert property (
      @(posedge bb_clk) disable iff (rst) (state == st_finished) |-> (op == op_none)
   );

endmodule

// ==== logic/sdram_cmd_issuer.sv ====
`timescale 1ns/1ps

module sdram_cmd_issuer
   import sched_pkg::*;
(
   input  logic                bb_clk,
   input  logic                rst,
   input  issue_op_e           op,
   input  logic                cmd_ready,
   input  logic [sample_w-1:0] aq_word,
   output logic                cmd_enable,
   output sdram_cmd_t          cmd,
   output logic                aq_pop,
   output logic                read_issued,
   output logic                store_full,
   output logic                play_done
);

   logic [sdram_addr_w:0] wr_ptr;   // one bit above the address so the count can pass its end
   logic [sdram_addr_w:0] rd_ptr;
   logic                  issue;

   assign issue = !cmd_enable && cmd_ready && (op != op_none);

   always_ff @(posedge bb_clk or posedge rst)
   begin
      if (rst)
      begin
         cmd_enable  <= 1'b0;
         aq_pop      <= 1'b0;
         read_issued <= 1'b0;
         wr_ptr      <= '0;
         rd_ptr      <= '0;
      end
      else
      begin
         cmd_enable  <= issue;
         aq_pop      <= issue && (op == op_write);
         read_issued <= issue && (op == op_read);
         if (issue && (op == op_write))
            wr_ptr <= wr_ptr + 1'b1;
         if (issue && (op == op_read))
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge bb_clk)
   begin
      if (issue)
      begin
         if (op == op_write)
         begin
            cmd.wr      <= 1'b1;
            cmd.address <= wr_ptr[sdram_addr_w-1:0];
            cmd.data    <= {{(word_w - sample_w){1'b0}}, aq_word};
         end
         else
         begin
            cmd.wr      <= 1'b0;
            cmd.address <= rd_ptr[sdram_addr_w-1:0];
            cmd.data    <= '0;
         end
      end
   end

   assign store_full = (wr_ptr >= fill_words);
   assign play_done  = (rd_ptr >= fill_words);

   a_enable_single : assert property (
      @(posedge bb_clk) disable iff (rst) cmd_enable |=> !cmd_enable
   );

   a_enable_after_ready : assert property (
      @(posedge bb_clk) disable iff (rst) cmd_enable |-> $past(cmd_ready)
   );

endmodule

// ==== logic/tx_fifo.sv ====
`timescale 1ns/1ps

module tx_fifo
   import sched_pkg::*;
(
   input  logic                 bb_clk,
   input  logic                 rst,
   input  logic                 read_issued,
   input  logic                 rd_valid,
   input  logic [word_w-1:0]    rd_data,
   input  logic                 tx_pop,
   output logic [word_w-1:0]    tx_data,
   output logic                 tx_empty,
   output logic [tx_fill_w-1:0] tx_fill
);

   logic [word_w-1:0]    mem [0:tx_depth-1];
   logic [tx_ptr_w-1:0]  wr_ptr;
   logic [tx_ptr_w-1:0]  rd_ptr;
   logic [tx_fill_w-1:0] count;   // words actually held
   logic                 pop;

   assign pop = tx_pop && !tx_empty;

   always_ff @(posedge bb_clk)
   begin
      if (rd_valid)
         mem[wr_ptr] <= rd_data;
   end

   always_ff @(posedge bb_clk or posedge rst)
   begin
      if (rst)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         tx_fill <= '0;
      end
      else
      begin
         if (rd_valid)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + tx_fill_w'(rd_valid) - tx_fill_w'(pop);
         // a slot is claimed when the read goes out, not when its data returns
         tx_fill <= tx_fill + tx_fill_w'(read_issued) - tx_fill_w'(pop);
      end
   end

   assign tx_data  = mem[rd_ptr];
   assign tx_empty = (count == '0);

   a_no_overflow : assert property (
      @(posedge bb_clk) disable iff (rst) rd_valid |-> (count != tx_depth)
   );

   a_no_underflow : assert property (
      @(posedge bb_clk) disable iff (rst) tx_pop |-> !tx_empty
   );

endmodule

// ==== logic/fifo_sdram_top.sv ====
`timescale 1ns/1ps

module fifo_sdram_top
   import sched_pkg::*;
(
   input  logic                write_clk,
   input  logic                sample_strobe,
   input  logic [sample_w-1:0] sample_data,
   input  logic                bb_clk,
   input  logic                rst,
   input  logic                cmd_ready,
   input  logic                rd_valid,
   input  logic [word_w-1:0]   rd_data,
   input  logic                tx_pop,
   output logic                cmd_enable,
   output sdram_cmd_t          cmd,
   output logic [word_w-1:0]   tx_data,
   output logic                tx_empty,
   output logic                bb_filled,
   output logic                tx_ready_for_first_read,
   output logic                finished,
   output sched_state_e        state
);

   logic                 aq_pending;
   logic [sample_w-1:0]  aq_word;
   logic                 aq_pop;
   issue_op_e            op;
   logic                 store_full;
   logic                 play_done;
   logic                 read_issued;
   logic [tx_fill_w-1:0] tx_fill;

   aq_capture i_aq_capture (
      .rst           (rst),
      .write_clk     (write_clk),
      .sample_strobe (sample_strobe),
      .sample_data   (sample_data),
      .bb_clk        (bb_clk),
      .aq_pop        (aq_pop),
      .aq_pending    (aq_pending),
      .aq_word       (aq_word)
   );

   fill_scheduler i_fill_scheduler (
      .bb_clk                  (bb_clk),
      .rst                     (rst),
      .aq_pending              (aq_pending),
      .store_full              (store_full),
      .play_done               (play_done),
      .tx_fill                 (tx_fill),
      .op                      (op),
      .state                   (state),
      .bb_filled               (bb_filled),
      .tx_ready_for_first_read (tx_ready_for_first_read),
      .finished                (finished)
   );

   sdram_cmd_issuer i_sdram_cmd_issuer (
      .bb_clk      (bb_clk),
      .rst         (rst),
      .op          (op),
      .cmd_ready   (cmd_ready),
      .aq_word     (aq_word),
      .cmd_enable  (cmd_enable),
      .cmd         (cmd),
      .aq_pop      (aq_pop),
      .read_issued (read_issued),
      .store_full  (store_full),
      .play_done   (play_done)
   );

   tx_fifo i_tx_fifo (
      .bb_clk      (bb_clk),
      .rst         (rst),
      .read_issued (read_issued),
      .rd_valid    (rd_valid),
      .rd_data     (rd_data),
      .tx_pop      (tx_pop),
      .tx_data     (tx_data),
      .tx_empty    (tx_empty),
      .tx_fill     (tx_fill)
   );

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen
(
   output logic bb_clk,
   output logic write_clk,
   output logic rst
);

   initial
   begin
      bb_clk = 1'b0;
      forever #50 bb_clk = ~bb_clk;
   end

   initial
   begin
      write_clk = 1'b0;
      #30;   // capture edges land 30 ns after each bb_clk edge
      forever #50 write_clk = ~write_clk;
   end

   initial
   begin
      rst = 1'b1;
      repeat (3) @(posedge bb_clk);
      #10;
      rst = 1'b0;
   end

endmodule

// ==== verif/tb_fifo_sdram.sv ====
`timescale 1ns/1ps

module tb_fifo_sdram
   import sched_pkg::*;
();

   logic                bb_clk;
   logic                write_clk;
   logic                rst;
   logic                sample_strobe;
   logic [sample_w-1:0] sample_data;
   logic                cmd_ready;
   logic                rd_valid;
   logic [word_w-1:0]   rd_data;
   logic                tx_pop;
   logic                cmd_enable;
   sdram_cmd_t          cmd;
   logic [word_w-1:0]   tx_data;
   logic                tx_empty;
   logic                bb_filled;
   logic                tx_ready_for_first_read;
   logic                finished;
   sched_state_e        state;

   integer              seed = 32'h1965_5133;
   logic [sample_w-1:0] samples [0:fill_words-1];
   logic [word_w-1:0]   sdram_mem [0:fill_words-1];

   int error_count  = 0;
   int tests_run    = 0;
   int tests_failed = 0;

   int                wr_count     = 0;
   int                rd_count     = 0;
   int                cmd_total    = 0;
   int                ready_mode   = 0;   // random cmd_ready when 0 and held low when 1
   logic              prev_enable  = 1'b0;
   logic [2:0]        pipe_valid   = '0;
   logic [word_w-1:0] pipe_data [0:2];

   tb_clk_gen i_clk_gen (
      .bb_clk    (bb_clk),
      .write_clk (write_clk),
      .rst       (rst)
   );

   fifo_sdram_top i_dut (.*);

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] expected);
      $display("ERR at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
      error_count++;
   endtask

   task automatic note_failure(input string what);
      $display("at %0t ns: %s", $time, what);
      error_count++;
   endtask

   task automatic close_test(input string name, input int start_errors);
      tests_run++;
      if (error_count == start_errors)
         $display("test %s passed", name);
      else
      begin
         tests_failed++;
         $display("test %s failed with %0d errors", name, error_count - start_errors);
      end
   endtask

   task automatic next_cycle();
      @(posedge bb_clk);
      #10;
   endtask

   task automatic strobe_samples(input int first, input int last);
      for (int i = first; i <= last; i++)
      begin
         @(posedge write_clk);
         #10;
         sample_strobe = 1'b1;
         sample_data   = samples[i];
      end
      @(posedge write_clk);
      #10;
      sample_strobe = 1'b0;
   endtask

   // the SDRAM model looks at commands 10 ns after each edge and returns reads 3 cycles later
   initial
   begin
      int mode_now;
      cmd_ready = 1'b0;
      rd_valid  = 1'b0;
      rd_data   = '0;
      for (int i = 0; i < 3; i++)
         pipe_data[i] = '0;
      forever
      begin
         @(posedge bb_clk);
         mode_now = ready_mode;
         #10;
         rd_valid      = pipe_valid[2];
         rd_data       = pipe_data[2];
         pipe_valid[2] = pipe_valid[1];
         pipe_data[2]  = pipe_data[1];
         pipe_valid[1] = pipe_valid[0];
         pipe_data[1]  = pipe_data[0];
         pipe_valid[0] = 1'b0;
         if (!rst && cmd_enable)
         begin
            assert (!prev_enable) else note_failure("cmd_enable high on two consecutive cycles");
            cmd_total++;
            if (cmd.wr)
            begin
               assert (rd_count == 0) else note_failure("write command after playback began");
               assert (cmd.address == sdram_addr_w'(wr_count))
                  else report_mismatch("cmd.address", cmd.address, wr_count);
               if (wr_count < fill_words)
               begin
                  assert (cmd.data == word_w'(samples[wr_count]))
                     else report_mismatch("cmd.data", cmd.data, word_w'(samples[wr_count]));
               end
               if (cmd.address < fill_words)
                  sdram_mem[cmd.address] = cmd.data;
               wr_count++;
            end
            else
            begin
               assert (wr_count == fill_words)
                  else note_failure("read issued before the store ended");
               assert (cmd.address == sdram_addr_w'(rd_count))
                  else report_mismatch("cmd.address", cmd.address, rd_count);
               pipe_valid[0] = 1'b1;
               pipe_data[0]  = (cmd.address < fill_words) ? sdram_mem[cmd.address] : '0;
               rd_count++;
            end
         end
         prev_enable = cmd_enable;
         if (mode_now == 1)
            cmd_ready = 1'b0;
         else
            cmd_ready = (($random(seed) & 3) != 0);   // ready about three cycles in four
      end
   end

   task automatic test_reset();
      int start_errors;
      int n;
      start_errors = error_count;
      n = 0;
      next_cycle();
      while (rst && n < 20)
      begin
         next_cycle();
         n++;
      end
      assert (!rst) else note_failure("reset was never released");
      next_cycle();
      assert (cmd_enable == 1'b0) else report_mismatch("cmd_enable", cmd_enable, 0);
      assert (bb_filled == 1'b0) else report_mismatch("bb_filled", bb_filled, 0);
      assert (tx_ready_for_first_read == 1'b0)
         else report_mismatch("tx_ready_for_first_read", tx_ready_for_first_read, 0);
      assert (finished == 1'b0) else report_mismatch("finished", finished, 0);
      assert (tx_empty == 1'b1) else report_mismatch("tx_empty", tx_empty, 1);
      assert (state == st_wait) else report_mismatch("state", state, st_wait);
      close_test("reset", start_errors);
   endtask

   task automatic test_store();
      int start_errors;
      int n;
      start_errors = error_count;
      strobe_samples(0, fill_words / 2 - 1);
      n = 0;
      while (wr_count < fill_words / 2 && n < 500)
      begin
         next_cycle();
         n++;
      end
      assert (wr_count == fill_words / 2)
         else report_mismatch("write count", wr_count, fill_words / 2);
      assert (rd_count == 0) else report_mismatch("read count", rd_count, 0);
      close_test("store", start_errors);
   endtask

   task automatic test_backpressure();
      int start_errors;
      int n;
      start_errors = error_count;
      ready_mode = 1;
      fork
         strobe_samples(fill_words / 2, fill_words - 1);
         begin
            for (int i = 0; i < 21; i++)
            begin
               next_cycle();
               if (i > 0)   // the first cycle may still carry a command issued before
               begin
                  assert (cmd_enable == 1'b0) else report_mismatch("cmd_enable", cmd_enable, 0);
               end
               if (i == 19)
                  ready_mode = 0;
            end
         end
      join
      n = 0;
      while (wr_count < fill_words && n < 1000)
      begin
         next_cycle();
         n++;
      end
      assert (wr_count == fill_words) else report_mismatch("write count", wr_count, fill_words);
      close_test("back-pressure", start_errors);
   endtask

   task automatic test_playback();
      int start_errors;
      int n;
      int held;
      int popped;
      start_errors = error_count;
      n = 0;
      while (!bb_filled && n < 500)
      begin
         next_cycle();
         n++;
      end
      assert (bb_filled) else note_failure("bb_filled never rose");
      n = 0;
      while (!tx_ready_for_first_read && n < 500)
      begin
         next_cycle();
         n++;
      end
      assert (tx_ready_for_first_read) else note_failure("tx_ready_for_first_read never rose");
      held = rd_count;
      repeat (12) next_cycle();   // long enough for every read in flight to return
      assert (rd_count == held) else report_mismatch("read count", rd_count, held);
      assert (rd_count <= tx_depth) else note_failure("more reads reserved than the FIFO holds");
      assert (state == st_hold) else report_mismatch("state", state, st_hold);
      assert (tx_empty == 1'b0) else report_mismatch("tx_empty", tx_empty, 0);
      popped = 0;
      n = 0;
      while (popped < fill_words && n < 3000)
      begin
         if (!tx_empty)
         begin
            assert (tx_data == word_w'(samples[popped]))
               else report_mismatch("tx_data", tx_data, word_w'(samples[popped]));
            tx_pop = 1'b1;
            popped++;
         end
         else
            tx_pop = 1'b0;
         next_cycle();
         n++;
      end
      tx_pop = 1'b0;
      assert (popped == fill_words) else report_mismatch("popped words", popped, fill_words);
      close_test("playback", start_errors);
   endtask

   task automatic test_finish();
      int start_errors;
      int n;
      int held;
      start_errors = error_count;
      n = 0;
      while (!finished && n < 200)
      begin
         next_cycle();
         n++;
      end
      assert (finished) else note_failure("finished never rose");
      assert (state == st_finished) else report_mismatch("state", state, st_finished);
      assert (rd_count == fill_words) else report_mismatch("read count", rd_count, fill_words);
      held = cmd_total;
      strobe_samples(0, 3);
      repeat (12) next_cycle();
      assert (cmd_total == held) else note_failure("command issued after the run finished");
      assert (tx_empty == 1'b1) else report_mismatch("tx_empty", tx_empty, 1);
      assert (finished == 1'b1) else report_mismatch("finished", finished, 1);
      close_test("finish", start_errors);
   endtask

   initial
   begin
      sample_strobe = 1'b0;
      sample_data   = '0;
      tx_pop        = 1'b0;
      for (int i = 0; i < fill_words; i++)
         samples[i] = sample_w'($random(seed));
      test_reset();
      test_store();
      test_backpressure();
      test_playback();
      test_finish();
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
      if (error_count == 0 && tests_failed == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   initial
   begin
      #1000000;
      $display("simulation stopped by the watchdog after 1 ms");
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== build.f ====
logic/sched_pkg.sv
logic/aq_capture.sv
logic/fill_scheduler.sv
logic/sdram_cmd_issuer.sv
logic/tx_fifo.sv
logic/fifo_sdram_top.sv
verif/tb_clk_gen.sv
verif/tb_fifo_sdram.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_fifo_sdram -f build.f \
   && ./obj_dir/Vtb_fifo_sdram | tee /dev/stderr | grep -x "RESULT: PASS" > /dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
